// File: list.f
+incdir+common
common/lane_runner_pkg.sv
keyboard/arrow_decoder.sv
rtl/move_input.sv
rtl/block_scanner.sv
rtl/lane_control.sv
rtl/lane_runner_top.sv
tests/tb_lane_runner.sv

// File: Makefile
# Verilator build and run for the lane runner

VERILATOR  ?= verilator
TOP        := tb_lane_runner
RTL_TOP    := lane_runner_top
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# A crashed simulator counts as a failure
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "RESULT: FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_lane_runner.sv
// ==========================================================
// Lane runner testbench
// Drives buttons and keyboard bytes, predicts the lane and
// the scans of each move, checks every pixel write
// ==========================================================

`timescale 1ns/100ps

`include "lane_runner_macros.svh"

module tb_lane_runner;

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;       // After rising edge
    localparam int SCAN_WRITES     = `LR_PLAYER_SIZE * `LR_PLAYER_SIZE;
    localparam int PLANNED_EVENTS  = 70;      // Directed plus random
    localparam int WATCHDOG_CYCLES = PLANNED_EVENTS * 2000 + 10000;
    localparam int SETTLE_LIMIT    = 4000;    // Cycles per event

    // Keyboard model states
    localparam logic [1:0] KB_IDLE  = 2'd0;
    localparam logic [1:0] KB_EXT   = 2'd1;
    localparam logic [1:0] KB_BREAK = 2'd2;

    // One expected scan, lane as seen during its writes
    typedef struct packed {
        lane_runner_pkg::lane_t   lane;
        lane_runner_pkg::color_t  color;
        lane_runner_pkg::xcoord_t x;
    } scan_t;

    logic                     Clock = 1'b0;
    logic                     reset;
    logic                     button_left_n;
    logic                     button_right_n;
    logic [7:0]               scan_code;
    logic                     scan_valid;
    lane_runner_pkg::lane_t   lane;
    lane_runner_pkg::xcoord_t pixel_x;
    lane_runner_pkg::ycoord_t pixel_y;
    lane_runner_pkg::color_t  pixel_color;
    logic                     pixel_write;

    // Reference model state
    scan_t                  expected_scans[$];
    lane_runner_pkg::lane_t ref_lane;
    logic                   idle_ready;       // Controller back in IDLE
    logic                   btn_l, btn_r;     // Buttons held
    logic                   key_l, key_r;     // Arrow keys held
    logic [1:0]             kb_state;
    logic                   kb_ext;           // Release of an E0 key
    logic [31:0]            rand_state = 32'h1a8bcac5;

    int    errors        = 0;
    int    scans_checked = 0;
    int    write_count   = 0;
    scan_t current_scan;
    logic  scan_expected = 1'b0;

    always #(CLK_PERIOD / 2) Clock = ~Clock;

    lane_runner_top uut (
        .Clock(Clock), .reset(reset),
        .button_left_n(button_left_n), .button_right_n(button_right_n),
        .scan_code(scan_code), .scan_valid(scan_valid),
        .lane(lane), .pixel_x(pixel_x), .pixel_y(pixel_y),
        .pixel_color(pixel_color), .pixel_write(pixel_write)
    );

    // ======================================================
    // Reference functions and model
    // ======================================================

    // Left column of the block in each lane
    function automatic lane_runner_pkg::xcoord_t expected_column(input int l);
        case (l)
            0:       return 9'd65;
            1:       return 9'd105;
            2:       return 9'd145;
            3:       return 9'd185;
            4:       return 9'd225;
            default: return '0;
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic tick();
        @(posedge Clock);
        #DRIVE_DELAY;
    endtask

    // Black scan at old lane, then cyan at new lane
    task automatic push_move(input lane_runner_pkg::lane_t new_lane);
        scan_t erase_scan;
        scan_t draw_scan;
        erase_scan.lane  = ref_lane;
        erase_scan.color = `LR_ERASE_COLOR;
        erase_scan.x     = expected_column(ref_lane);
        draw_scan.lane   = new_lane;
        draw_scan.color  = `LR_PLAYER_COLOR;
        draw_scan.x      = expected_column(new_lane);
        expected_scans.push_back(erase_scan);
        expected_scans.push_back(draw_scan);
        ref_lane   = new_lane;
        idle_ready = 1'b0;               // Held request parks it
    endtask

    task automatic update_model();
        logic req_l;
        logic req_r;
        req_l = btn_l | key_l;
        req_r = btn_r | key_r;
        if (!idle_ready && !req_l && !req_r)
            idle_ready = 1'b1;           // All released
        if (idle_ready) begin
            if (req_l && ref_lane > 0)
                push_move(ref_lane - 1'b1);
            else if (req_r && ref_lane < `LR_NUM_LANES - 1)
                push_move(ref_lane + 1'b1);
        end
    endtask

    // E0 code sets, E0 F0 code clears, F0 eats one byte
    task automatic decode_model(input logic [7:0] b);
        case (kb_state)
            KB_IDLE: begin
                if (b == `LR_SCAN_EXTENDED)
                    kb_state = KB_EXT;
                else if (b == `LR_SCAN_BREAK)
                    kb_state = KB_BREAK;
            end
            KB_EXT: begin
                kb_state = KB_IDLE;
                if (b == `LR_SCAN_BREAK) begin
                    kb_ext   = 1'b1;
                    kb_state = KB_BREAK;
                end else if (b == `LR_SCAN_LEFT) begin
                    key_l = 1'b1;
                end else if (b == `LR_SCAN_RIGHT) begin
                    key_r = 1'b1;
                end
            end
            default: begin
                if (kb_ext && b == `LR_SCAN_LEFT)
                    key_l = 1'b0;
                else if (kb_ext && b == `LR_SCAN_RIGHT)
                    key_r = 1'b0;
                kb_ext   = 1'b0;
                kb_state = KB_IDLE;
            end
        endcase
    endtask

    // ======================================================
    // Stimulus tasks
    // ======================================================
    task automatic settle();
        int cycles;
        cycles = 0;
        repeat (6) tick();               // Sync flops and FSM
        while ((expected_scans.size() != 0 || pixel_write) && cycles < SETTLE_LIMIT) begin
            tick();
            cycles++;
        end
        if (expected_scans.size() != 0 || pixel_write) begin
            $display("Expected pixel writes never completed, time %0t", $time);
            errors++;
            expected_scans.delete();
        end
        repeat (2) tick();
        check_value(int'(lane), int'(ref_lane), "lane after event");
    endtask

    task automatic send_byte(input logic [7:0] b);
        scan_code  = b;
        scan_valid = 1'b1;               // One-cycle strobe
        tick();
        scan_valid = 1'b0;
        decode_model(b);
        update_model();
    endtask

    task automatic set_button(input logic left, input logic pressed);
        if (left) begin
            button_left_n = !pressed;
            btn_l         = pressed;
        end else begin
            button_right_n = !pressed;
            btn_r          = pressed;
        end
        update_model();
        settle();
    endtask

    task automatic key_press(input logic [7:0] code);
        send_byte(`LR_SCAN_EXTENDED);
        send_byte(code);
        settle();
    endtask

    task automatic key_release(input logic [7:0] code);
        send_byte(`LR_SCAN_EXTENDED);
        send_byte(`LR_SCAN_BREAK);
        send_byte(code);
        settle();
    endtask

    task automatic toggle_source(input logic [1:0] idx);
        case (idx)
            2'd0: set_button(1'b1, !btn_l);
            2'd1: set_button(1'b0, !btn_r);
            2'd2: begin
                if (key_l) key_release(`LR_SCAN_LEFT);
                else       key_press(`LR_SCAN_LEFT);
            end
            default: begin
                if (key_r) key_release(`LR_SCAN_RIGHT);
                else       key_press(`LR_SCAN_RIGHT);
            end
        endcase
    endtask

    // ======================================================
    // Compare process, every write against the queue
    // ======================================================
    always @(negedge Clock) begin
        if (!reset && pixel_write === 1'b1) begin
            if (write_count == 0) begin
                scan_expected = (expected_scans.size() != 0);
                if (scan_expected)
                    current_scan = expected_scans.pop_front();
                else begin
                    $display("Pixel writes started with no scan expected, time %0t", $time);
                    errors++;
                end
            end
            if (scan_expected) begin
                check_value(int'(pixel_x),
                            int'(current_scan.x) + write_count % `LR_PLAYER_SIZE, "pixel_x");
                check_value(int'(pixel_y),
                            `LR_PLAYER_Y + write_count / `LR_PLAYER_SIZE, "pixel_y");
                check_value(int'(pixel_color), int'(current_scan.color), "pixel_color");
                check_value(int'(lane), int'(current_scan.lane), "lane during scan");
            end
            write_count++;
        end else if (write_count != 0) begin
            if (scan_expected) begin
                check_value(write_count, SCAN_WRITES, "writes in scan");
                scans_checked++;
            end
            write_count = 0;             // Scan ended
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // ======================================================
    // Main sequence
    // ======================================================
    initial begin
        scan_t first_scan;
        reset          = 1'b1;
        button_left_n  = 1'b1;
        button_right_n = 1'b1;
        scan_code      = 8'h00;
        scan_valid     = 1'b0;
        ref_lane       = `LR_START_LANE;
        idle_ready     = 1'b1;           // No release needed after reset
        btn_l          = 1'b0;
        btn_r          = 1'b0;
        key_l          = 1'b0;
        key_r          = 1'b0;
        kb_state       = KB_IDLE;
        kb_ext         = 1'b0;

        // Initial cyan block in the middle lane
        first_scan.lane  = `LR_START_LANE;
        first_scan.color = `LR_PLAYER_COLOR;
        first_scan.x     = expected_column(`LR_START_LANE);
        expected_scans.push_back(first_scan);

        repeat (4) @(posedge Clock);
        #DRIVE_DELAY;
        check_value(int'(pixel_write), 0, "pixel_write in reset");
        check_value(int'(lane), `LR_START_LANE, "lane in reset");
        reset = 1'b0;
        settle();
        check_value(scans_checked, 1, "scans after reset");

        // Buttons, one lane each way
        set_button(1'b0, 1'b1);
        set_button(1'b0, 1'b0);
        set_button(1'b1, 1'b1);
        set_button(1'b1, 1'b0);

        // Edges, out of range requests ignored
        repeat (2) begin
            set_button(1'b1, 1'b1);
            set_button(1'b1, 1'b0);
        end
        check_value(int'(lane), 0, "lane at left edge");
        set_button(1'b1, 1'b1);
        set_button(1'b1, 1'b0);
        repeat (4) begin
            set_button(1'b0, 1'b1);
            set_button(1'b0, 1'b0);
        end
        check_value(int'(lane), 4, "lane at right edge");
        set_button(1'b0, 1'b1);
        set_button(1'b0, 1'b0);

        // Keyboard arrows
        key_press(`LR_SCAN_LEFT);
        key_press(`LR_SCAN_LEFT);        // Still held, no move
        key_release(`LR_SCAN_LEFT);
        key_press(`LR_SCAN_LEFT);
        key_release(`LR_SCAN_LEFT);
        key_press(`LR_SCAN_RIGHT);
        key_release(`LR_SCAN_RIGHT);
        send_byte(`LR_SCAN_BREAK);       // Plain break, byte eaten
        send_byte(`LR_SCAN_LEFT);
        settle();
        send_byte(8'h1C);
        settle();
        send_byte(`LR_SCAN_EXTENDED);    // E0 then a non-arrow
        send_byte(8'h1C);
        settle();
        check_value(int'(lane), 3, "lane after keyboard moves");

        // Random presses and releases over all four sources
        repeat (30) begin
            rand_state = xorshift32(rand_state);
            toggle_source(rand_state[9:8]);
        end
        if (btn_l) set_button(1'b1, 1'b0);
        if (btn_r) set_button(1'b0, 1'b0);
        if (key_l) key_release(`LR_SCAN_LEFT);
        if (key_r) key_release(`LR_SCAN_RIGHT);

        $display("Run complete: %0d scans checked, %0d errors", scans_checked, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: rtl/lane_runner_top.sv
// ==========================================================
// Lane runner top level
// Keyboard decode and button conditioning feed the lane
// controller, which drives the pixel-write stream
// ==========================================================

`timescale 1ns/100ps

module lane_runner_top (
    input  logic                      Clock,
    input  logic                      reset,
    input  logic                      button_left_n,
    input  logic                      button_right_n,
    input  logic [7:0]                scan_code,
    input  logic                      scan_valid,
    output lane_runner_pkg::lane_t    lane,
    output lane_runner_pkg::xcoord_t  pixel_x,
    output lane_runner_pkg::ycoord_t  pixel_y,
    output lane_runner_pkg::color_t   pixel_color,
    output logic                      pixel_write
);

    logic                     arrow_left, arrow_right;   // Keyboard levels
    logic                     move_left, move_right;     // Merged requests
    logic                     scan_start, scan_done;
    lane_runner_pkg::xcoord_t origin_x;
    lane_runner_pkg::color_t  color;

    arrow_decoder u_arrow_decoder (
        .Clock(Clock), .reset(reset),
        .scan_code(scan_code), .scan_valid(scan_valid),
        .arrow_left(arrow_left), .arrow_right(arrow_right)
    );

    move_input u_move_input (
        .Clock(Clock), .reset(reset),
        .button_left_n(button_left_n), .button_right_n(button_right_n),
        .arrow_left(arrow_left), .arrow_right(arrow_right),
        .move_left(move_left), .move_right(move_right)
    );

    lane_control u_lane_control (
        .Clock(Clock), .reset(reset),
        .move_left(move_left), .move_right(move_right),
        .lane(lane), .scan_start(scan_start),
        .origin_x(origin_x), .color(color), .scan_done(scan_done)
    );

    block_scanner u_block_scanner (
        .Clock(Clock), .reset(reset),
        .scan_start(scan_start), .origin_x(origin_x), .color(color),
        .pixel_x(pixel_x), .pixel_y(pixel_y), .pixel_color(pixel_color),
        .pixel_write(pixel_write), .scan_done(scan_done)
    );

endmodule

// File: rtl/lane_control.sv
// ==========================================================
// Lane controller
// Owns the player lane and sequences the initial draw and
// the erase, move and draw steps of each lane change
// ==========================================================

`timescale 1ns/100ps

`include "lane_runner_macros.svh"

module lane_control (
    input  logic                      Clock,
    input  logic                      reset,
    input  logic                      move_left,
    input  logic                      move_right,
    output lane_runner_pkg::lane_t    lane,
    output logic                      scan_start,
    output lane_runner_pkg::xcoord_t  origin_x,
    output lane_runner_pkg::color_t   color,
    input  logic                      scan_done
);

    lane_runner_pkg::ctrl_state_t state;
    lane_runner_pkg::lane_t       target_lane;

    // Left column of the block, centred in its lane
    function automatic lane_runner_pkg::xcoord_t lane_to_x(input lane_runner_pkg::lane_t l);
        return lane_runner_pkg::xcoord_t'(`LR_LANE_START_X + l * `LR_LANE_WIDTH
            + (`LR_LANE_WIDTH - `LR_PLAYER_SIZE) / 2);
    endfunction

    // Black only while erasing
    assign color = (state == lane_runner_pkg::ERASE) ?
                   lane_runner_pkg::color_t'(`LR_ERASE_COLOR) :
                   lane_runner_pkg::color_t'(`LR_PLAYER_COLOR);

    // ======================================================
    // Controller FSM
    // ======================================================
    always_ff @(posedge Clock) begin
        if (reset) begin
            state       <= lane_runner_pkg::INIT;
            lane        <= lane_runner_pkg::lane_t'(`LR_START_LANE);
            target_lane <= lane_runner_pkg::lane_t'(`LR_START_LANE);
            origin_x    <= lane_to_x(lane_runner_pkg::lane_t'(`LR_START_LANE));
            scan_start  <= 1'b0;
        end else begin
            scan_start <= 1'b0;  // Single-cycle pulse
            case (state)
                lane_runner_pkg::INIT: begin
                    scan_start <= 1'b1;
                    state      <= lane_runner_pkg::DRAW_INITIAL;
                end

                lane_runner_pkg::DRAW_INITIAL: begin
                    if (scan_done)
                        state <= lane_runner_pkg::IDLE;
                end

                lane_runner_pkg::IDLE: begin
                    // Left wins when both are requested
                    if (move_left && lane != '0) begin
                        target_lane <= lane - 1'b1;
                        scan_start  <= 1'b1;
                        state       <= lane_runner_pkg::ERASE;
                    end else if (move_right && lane != `LR_NUM_LANES - 1) begin
                        target_lane <= lane + 1'b1;
                        scan_start  <= 1'b1;
                        state       <= lane_runner_pkg::ERASE;
                    end
                end

                lane_runner_pkg::ERASE: begin
                    if (scan_done)
                        state <= lane_runner_pkg::MOVE;
                end

                lane_runner_pkg::MOVE: begin
                    lane       <= target_lane;
                    origin_x   <= lane_to_x(target_lane);
                    scan_start <= 1'b1;        // Cyan scan at new column
                    state      <= lane_runner_pkg::DRAW;
                end

                lane_runner_pkg::DRAW: begin
                    if (scan_done)
                        state <= lane_runner_pkg::WAIT_RELEASE;
                end

                lane_runner_pkg::WAIT_RELEASE: begin
                    if (!move_left && !move_right)
                        state <= lane_runner_pkg::IDLE;
                end

                default: state <= lane_runner_pkg::INIT;
            endcase
        end
    end

    a_lane_range: assert property (
        @(posedge Clock) disable iff (reset) lane < `LR_NUM_LANES
    );

endmodule

// File: rtl/block_scanner.sv
// ==========================================================
// Player block scanner
// Walks the square block row by row and emits one
// registered pixel write per cycle from a start strobe
// ==========================================================

`timescale 1ns/100ps

`include "lane_runner_macros.svh"

module block_scanner (
    input  logic                      Clock,
    input  logic                      reset,
    input  logic                      scan_start,
    input  lane_runner_pkg::xcoord_t  origin_x,
    input  lane_runner_pkg::color_t   color,
    output lane_runner_pkg::xcoord_t  pixel_x,
    output lane_runner_pkg::ycoord_t  pixel_y,
    output lane_runner_pkg::color_t   pixel_color,
    output logic                      pixel_write,
    output logic                      scan_done
);

    localparam int CNT_W = $clog2(`LR_PLAYER_SIZE);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`LR_PLAYER_SIZE - 1);

    logic             busy;
    logic [CNT_W-1:0] col;    // Column of pixel on the outputs
    logic [CNT_W-1:0] row;    // Row of pixel on the outputs
    logic             last_pixel;

    assign last_pixel = (col == LAST) && (row == LAST);
    assign scan_done  = busy && last_pixel;  // High on final write

    // ======================================================
    // Busy flag and write enable
    // ======================================================
    always_ff @(posedge Clock) begin
        if (reset) begin
            busy        <= 1'b0;
            pixel_write <= 1'b0;
        end else if (scan_start) begin
            busy        <= 1'b1;
            pixel_write <= 1'b1;
        end else if (scan_done) begin
            busy        <= 1'b0;
            pixel_write <= 1'b0;
        end
    end

    // Counters and pixel payload
    always_ff @(posedge Clock) begin
        if (scan_start) begin
            col         <= '0;
            row         <= '0;
            pixel_x     <= origin_x;
            pixel_y     <= lane_runner_pkg::ycoord_t'(`LR_PLAYER_Y);
            pixel_color <= color;
        end else if (busy && !last_pixel) begin
            if (col == LAST) begin
                col     <= '0;            // Next row
                row     <= row + 1'b1;
                pixel_x <= origin_x;
                pixel_y <= pixel_y + 1'b1;
            end else begin
                col     <= col + 1'b1;
                pixel_x <= pixel_x + 1'b1;
            end
        end
    end

    a_no_start_busy: assert property (
        @(posedge Clock) disable iff (reset) scan_start |-> !busy
    );

    // Final write sits on the bottom row of the block
    a_done_last_row: assert property (
        @(posedge Clock) disable iff (reset)
        scan_done |-> pixel_y == lane_runner_pkg::ycoord_t'(`LR_PLAYER_Y + `LR_PLAYER_SIZE - 1)
    );

endmodule

// File: rtl/move_input.sv
// ==========================================================
// Move request conditioning
// Synchronizes the active-low push buttons and merges them
// with the keyboard arrow levels
// ==========================================================

`timescale 1ns/100ps

module move_input (
    input  logic Clock,
    input  logic reset,
    input  logic button_left_n,
    input  logic button_right_n,
    input  logic arrow_left,
    input  logic arrow_right,
    output logic move_left,
    output logic move_right
);

    // Bit 1 left, bit 0 right
    logic [1:0] button_meta;
    logic [1:0] button_sync;

    // ======================================================
    // Two-flop synchronizer, buttons inverted on entry
    // ======================================================
    always_ff @(posedge Clock) begin
        if (reset) begin
            button_meta <= 2'b00;
            button_sync <= 2'b00;
        end else begin
            button_meta <= ~{button_left_n, button_right_n};
            button_sync <= button_meta;
        end
    end

    // Keyboard levels are already synchronous
    assign move_left  = button_sync[1] | arrow_left;
    assign move_right = button_sync[0] | arrow_right;

endmodule

// File: keyboard/arrow_decoder.sv
// ==========================================================
// Arrow key decoder
// Follows the keyboard byte stream and holds one level per
// arrow key, set by E0 code and cleared by E0 F0 code
// ==========================================================

`timescale 1ns/100ps

`include "lane_runner_macros.svh"

module arrow_decoder (
    input  logic       Clock,
    input  logic       reset,
    input  logic [7:0] scan_code,
    input  logic       scan_valid,
    output logic       arrow_left,
    output logic       arrow_right
);

    // Decoder states
    localparam logic [1:0] WAIT_CODE     = 2'd0;
    localparam logic [1:0] WAIT_EXTENDED = 2'd1;
    localparam logic [1:0] WAIT_BREAK    = 2'd2;

    logic [1:0] decode_state;
    logic       ext_break;   // Release belongs to an extended key

    // ======================================================
    // Byte decoder, advances only on a strobe
    // ======================================================
    always_ff @(posedge Clock) begin
        if (reset) begin
            decode_state <= WAIT_CODE;
            ext_break    <= 1'b0;
            arrow_left   <= 1'b0;
            arrow_right  <= 1'b0;
        end else if (scan_valid) begin
            case (decode_state)
                WAIT_CODE: begin
                    if (scan_code == `LR_SCAN_EXTENDED)
                        decode_state <= WAIT_EXTENDED;
                    else if (scan_code == `LR_SCAN_BREAK)
                        decode_state <= WAIT_BREAK;  // Plain key release
                end

                WAIT_EXTENDED: begin
                    decode_state <= WAIT_CODE;       // Unless a release follows
                    if (scan_code == `LR_SCAN_BREAK) begin
                        ext_break    <= 1'b1;
                        decode_state <= WAIT_BREAK;
                    end else if (scan_code == `LR_SCAN_LEFT) begin
                        arrow_left <= 1'b1;          // Left pressed
                    end else if (scan_code == `LR_SCAN_RIGHT) begin
                        arrow_right <= 1'b1;         // Right pressed
                    end
                end

                WAIT_BREAK: begin
                    // Byte after F0 is always consumed
                    if (ext_break) begin
                        if (scan_code == `LR_SCAN_LEFT)
                            arrow_left <= 1'b0;
                        else if (scan_code == `LR_SCAN_RIGHT)
                            arrow_right <= 1'b0;
                    end
                    ext_break    <= 1'b0;
                    decode_state <= WAIT_CODE;
                end

                default: decode_state <= WAIT_CODE;
            endcase
        end
    end

    // Extended release flag only lives while the byte after F0 is awaited
    a_ext_break_state: assert property (
        @(posedge Clock) disable iff (reset)
        ext_break |-> decode_state == WAIT_BREAK
    );

endmodule

// File: common/lane_runner_pkg.sv
// ==========================================================
// Lane runner shared types
// Lane number, pixel coordinates, 9-bit colour and the
// lane controller state encoding
// ==========================================================

package lane_runner_pkg;

    // Lane index 0..4
    typedef logic [2:0] lane_t;

    // Pixel column on the 320 wide frame
    typedef logic [8:0] xcoord_t;

    // Pixel row on the 240 high frame
    typedef logic [7:0] ycoord_t;

    // 3 bits per channel, red in the top bits
    typedef logic [8:0] color_t;

    // ======================================================
    // Lane controller FSM states
    // ======================================================
    typedef enum logic [2:0] {
        INIT         = 3'd0,  // One cycle after reset
        DRAW_INITIAL = 3'd1,  // First cyan block in start lane
        IDLE         = 3'd2,  // Waiting for a move request
        ERASE        = 3'd3,  // Black scan at old lane
        MOVE         = 3'd4,  // Lane and origin update
        DRAW         = 3'd5,  // Cyan scan at new lane
        WAIT_RELEASE = 3'd6   // Hold until requests drop
    } ctrl_state_t;

endpackage

// File: common/lane_runner_macros.svh
// ==========================================================
// Lane runner constants
// Lane geometry, player block size and position, colours
// and the keyboard scan codes of interest
// ==========================================================

`ifndef LANE_RUNNER_MACROS_SVH
`define LANE_RUNNER_MACROS_SVH

// ==========================================================
// Lane geometry
// ==========================================================
`define LR_NUM_LANES     5     // Lanes across the road
`define LR_LANE_WIDTH    40    // Pixels per lane
`define LR_LANE_START_X  60    // Left edge of lane 0
`define LR_START_LANE    2     // Middle lane after reset

// ==========================================================
// Player block
// ==========================================================
`define LR_PLAYER_SIZE   30    // Square side in pixels
`define LR_PLAYER_Y      180   // Top row, fixed near bottom

// Cyan block on black road
`define LR_PLAYER_COLOR  9'b000_111_111
`define LR_ERASE_COLOR   9'b000_000_000

// ==========================================================
// Keyboard scan codes, set 2
// ==========================================================
`define LR_SCAN_EXTENDED 8'hE0  // Extended key prefix
`define LR_SCAN_BREAK    8'hF0  // Key release prefix
`define LR_SCAN_LEFT     8'h6B  // Left arrow after E0
`define LR_SCAN_RIGHT    8'h74  // Right arrow after E0

`endif
